//--- logic/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Address widths
`define DC_VADDR_W 32
`define DC_PADDR_W 15
`define DC_PAGE_OFS_W 12
`define DC_VPN_W 20
`define DC_PFN_W 3

`define DC_TLB_ENTRIES 8

// Data widths
`define DC_WORD_W 32
`define DC_LINE_W 128
`define DC_BEATS 4

// Physical address fields
`define DC_BANK_BIT 4
`define DC_INDEX_LO 5
`define DC_INDEX_HI 8
`define DC_TAG_LO 9

`endif

//--- logic/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_t;

   typedef enum logic [1:0] {
      FAULT_NONE       = 2'd0,
      FAULT_TLB_MISS   = 2'd1,
      FAULT_PROTECTION = 2'd2
   } fault_t;

   typedef enum logic [1:0] {
      FILL_IDLE  = 2'd0,
      FILL_BEAT  = 2'd1,
      FILL_STORE = 2'd2,
      FILL_DONE  = 2'd3
   } fill_state_t;

   typedef struct packed {
      logic                 valid;
      logic                 writable;
      logic [`DC_VPN_W-1:0] vpn;
      logic [`DC_PFN_W-1:0] pfn;
   } tlb_entry_t;

   typedef struct packed {
      mem_op_t                op;
      logic [`DC_PADDR_W-1:0] paddr;
      logic [`DC_WORD_W-1:0]  wdata;
   } xlat_req_t;

   typedef struct packed {
      mem_op_t                op;
      logic [`DC_PADDR_W-1:0] paddr;
      logic [`DC_WORD_W-1:0]  wdata;
   } fill_req_t;

   typedef struct packed {
      logic [`DC_INDEX_HI-`DC_INDEX_LO:0]    index;
      logic [`DC_PADDR_W-`DC_TAG_LO-1:0]     tag;
      logic [`DC_LINE_W-1:0]                 line;
   } line_fill_t;

   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [`DC_VADDR_W-1:0] adr;
      logic [`DC_WORD_W-1:0]  dat;
   } wb_m2s_t;

   typedef struct packed {
      logic                  ack;
      logic                  err;
      logic [`DC_WORD_W-1:0] dat;
   } wb_s2m_t;

endpackage

//--- logic/cache_bank.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module cache_bank (
   input  logic                               clk,
   input  logic                               reset_i,
   input  logic [`DC_INDEX_HI-`DC_INDEX_LO:0] index_i,
   input  logic [`DC_PADDR_W-`DC_TAG_LO-1:0]  tag_i,
   input  logic [`DC_BANK_BIT-3:0]            word_sel_i,
   output logic                               hit_o,
   output logic [`DC_WORD_W-1:0]              word_o,
   input  logic                               install_i,
   input  logic [`DC_LINE_W-1:0]              line_i,
   input  logic                               word_we_i,
   input  logic [`DC_WORD_W-1:0]              wdata_i
);

   localparam int SETS = 1 << (`DC_INDEX_HI - `DC_INDEX_LO + 1);

   logic [SETS-1:0]                    valid_q;
   logic [`DC_PADDR_W-`DC_TAG_LO-1:0]  tag_q  [SETS];
   logic [`DC_LINE_W-1:0]              line_q [SETS];

   // Direct mapped lookup
   assign hit_o  = valid_q[index_i] && (tag_q[index_i] == tag_i);
   assign word_o = line_q[index_i][word_sel_i*`DC_WORD_W +: `DC_WORD_W];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         valid_q <= '0;
      end else if (install_i) begin
         valid_q[index_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (install_i) begin
         tag_q[index_i]  <= tag_i;
         line_q[index_i] <= line_i;
      end else if (word_we_i) begin
         // Store hit updates one word in place
         line_q[index_i][word_sel_i*`DC_WORD_W +: `DC_WORD_W] <= wdata_i;
      end
   end

endmodule

//--- logic/tlb_stage.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module tlb_stage (
   input  logic                                         clk,
   input  logic                                         reset_i,
   input  dcache_pkg::wb_m2s_t                          core_i,
   input  dcache_pkg::tlb_entry_t [`DC_TLB_ENTRIES-1:0] tlb_entries_i,
   input  logic                                         stage_done_i,
   output logic                                         xlat_valid_o,
   output dcache_pkg::xlat_req_t                        xlat_req_o,
   output logic                                         err_o,
   output dcache_pkg::fault_t                           fault_o
);

   logic                   pending_q;
   logic                   busy;
   logic                   start;
   logic [`DC_VADDR_W-1:0] vaddr_q;
   dcache_pkg::mem_op_t    op_q;
   logic [`DC_WORD_W-1:0]  wdata_q;
   logic                   hit;
   logic                   hit_writable;
   logic [`DC_PFN_W-1:0]   hit_pfn;
   dcache_pkg::fault_t     fault_next;

   // Err cycle counts as busy so a held stb is not taken twice
   assign busy  = pending_q | xlat_valid_o | err_o;
   assign start = !busy && core_i.cyc && core_i.stb;

   // Fully associative match on the registered VPN
   always_comb begin
      hit          = 1'b0;
      hit_writable = 1'b0;
      hit_pfn      = '0;
      for (int i = 0; i < `DC_TLB_ENTRIES; i++) begin
         if (tlb_entries_i[i].valid &&
             tlb_entries_i[i].vpn == vaddr_q[`DC_VADDR_W-1:`DC_PAGE_OFS_W]) begin
            hit          = 1'b1;
            hit_writable = tlb_entries_i[i].writable;
            hit_pfn      = tlb_entries_i[i].pfn;
         end
      end
   end

   always_comb begin
      if (!hit) begin
         fault_next = dcache_pkg::FAULT_TLB_MISS;
      end else if (op_q == dcache_pkg::OP_WRITE && !hit_writable) begin
         fault_next = dcache_pkg::FAULT_PROTECTION;
      end else begin
         fault_next = dcache_pkg::FAULT_NONE;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         pending_q    <= 1'b0;
         xlat_valid_o <= 1'b0;
         err_o        <= 1'b0;
         fault_o      <= dcache_pkg::FAULT_NONE;
      end else begin
         err_o <= 1'b0;
         if (start) begin
            pending_q <= 1'b1;
            fault_o   <= dcache_pkg::FAULT_NONE;
         end
         if (pending_q) begin
            pending_q <= 1'b0;
            if (fault_next != dcache_pkg::FAULT_NONE) begin
               err_o   <= 1'b1;
               fault_o <= fault_next;
            end else begin
               xlat_valid_o <= 1'b1;
            end
         end
         if (xlat_valid_o && stage_done_i) begin
            xlat_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         vaddr_q <= core_i.adr;
         op_q    <= core_i.we ? dcache_pkg::OP_WRITE : dcache_pkg::OP_READ;
         wdata_q <= core_i.dat;
      end
      if (pending_q) begin
         xlat_req_o.op    <= op_q;
         xlat_req_o.paddr <= {hit_pfn, vaddr_q[`DC_PAGE_OFS_W-1:0]};
         xlat_req_o.wdata <= wdata_q;
      end
   end

endmodule

//--- logic/bank_stage.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module bank_stage (
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic                   xlat_valid_i,
   input  dcache_pkg::xlat_req_t  xlat_req_i,
   input  logic                   fill_done_i,
   input  dcache_pkg::line_fill_t line_fill_i,
   input  logic [`DC_WORD_W-1:0]  fill_word_i,
   output logic                   fill_valid_o,
   output dcache_pkg::fill_req_t  fill_req_o,
   output logic                   ack_o,
   output logic [`DC_WORD_W-1:0]  rdata_o,
   output logic                   stage_done_o
);

   logic                                 busy_q;
   logic                                 bank_sel;
   logic [`DC_INDEX_HI-`DC_INDEX_LO:0]   index;
   logic [`DC_PADDR_W-`DC_TAG_LO-1:0]    tag;
   logic [`DC_BANK_BIT-3:0]              word_sel;
   logic                                 even_hit;
   logic                                 odd_hit;
   logic [`DC_WORD_W-1:0]                even_word;
   logic [`DC_WORD_W-1:0]                odd_word;
   logic                                 sel_hit;
   logic [`DC_WORD_W-1:0]                sel_word;
   logic                                 start;
   logic                                 is_read;
   logic                                 install;
   logic                                 word_we;

   assign bank_sel = xlat_req_i.paddr[`DC_BANK_BIT];
   assign word_sel = xlat_req_i.paddr[`DC_BANK_BIT-1:2];
   // Returned fill carries the set it belongs to
   assign index = fill_done_i ? line_fill_i.index
                              : xlat_req_i.paddr[`DC_INDEX_HI:`DC_INDEX_LO];
   assign tag   = fill_done_i ? line_fill_i.tag
                              : xlat_req_i.paddr[`DC_PADDR_W-1:`DC_TAG_LO];

   assign sel_hit  = bank_sel ? odd_hit : even_hit;
   assign sel_word = bank_sel ? odd_word : even_word;
   assign is_read  = xlat_req_i.op == dcache_pkg::OP_READ;
   assign start    = xlat_valid_i && !busy_q && !stage_done_o;
   assign install  = busy_q && fill_done_i && is_read;
   // No write allocate
   assign word_we  = busy_q && fill_done_i && !is_read && sel_hit;

   cache_bank u_bank_even (
      .clk(clk), .reset_i(reset_i),
      .index_i(index), .tag_i(tag), .word_sel_i(word_sel),
      .hit_o(even_hit), .word_o(even_word),
      .install_i(install && !bank_sel), .line_i(line_fill_i.line),
      .word_we_i(word_we && !bank_sel), .wdata_i(xlat_req_i.wdata)
   );

   cache_bank u_bank_odd (
      .clk(clk), .reset_i(reset_i),
      .index_i(index), .tag_i(tag), .word_sel_i(word_sel),
      .hit_o(odd_hit), .word_o(odd_word),
      .install_i(install && bank_sel), .line_i(line_fill_i.line),
      .word_we_i(word_we && bank_sel), .wdata_i(xlat_req_i.wdata)
   );

   assign stage_done_o = ack_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         busy_q       <= 1'b0;
         fill_valid_o <= 1'b0;
         ack_o        <= 1'b0;
      end else begin
         ack_o <= 1'b0;
         if (start) begin
            if (is_read && sel_hit) begin
               ack_o <= 1'b1;
            end else begin
               busy_q       <= 1'b1;
               fill_valid_o <= 1'b1;
            end
         end
         if (busy_q && fill_done_i) begin
            busy_q       <= 1'b0;
            fill_valid_o <= 1'b0;
            ack_o        <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         fill_req_o.op    <= xlat_req_i.op;
         fill_req_o.paddr <= xlat_req_i.paddr;
         fill_req_o.wdata <= xlat_req_i.wdata;
         rdata_o          <= sel_word;
      end else if (busy_q && fill_done_i) begin
         rdata_o <= fill_word_i;
      end
   end

endmodule

//--- logic/fill_stage.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module fill_stage (
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic                   fill_valid_i,
   input  dcache_pkg::fill_req_t  fill_req_i,
   output dcache_pkg::wb_m2s_t    mem_o,
   input  dcache_pkg::wb_s2m_t    mem_i,
   output logic                   fill_done_o,
   output dcache_pkg::line_fill_t line_fill_o,
   output logic [`DC_WORD_W-1:0]  fill_word_o
);

   localparam int BEAT_W = $clog2(`DC_BEATS);

   dcache_pkg::fill_state_t state_q;
   logic                    stb_q;
   logic [BEAT_W-1:0]       beat_q;
   dcache_pkg::fill_req_t   req_q;
   logic [`DC_LINE_W-1:0]   line_q;
   logic                    beat_end;
   logic                    is_store;
   logic [`DC_BANK_BIT-3:0] word_sel;

   assign is_store = state_q == dcache_pkg::FILL_STORE;
   assign word_sel = req_q.paddr[`DC_BANK_BIT-1:2];
   // Err from memory also ends the beat so the pipeline cannot hang
   assign beat_end = stb_q && (mem_i.ack || mem_i.err);

   assign mem_o.cyc = stb_q;
   assign mem_o.stb = stb_q;
   assign mem_o.we  = is_store;
   assign mem_o.dat = req_q.wdata;
   assign mem_o.adr = is_store
      ? {{(`DC_VADDR_W-`DC_PADDR_W){1'b0}}, req_q.paddr[`DC_PADDR_W-1:2], 2'b00}
      : {{(`DC_VADDR_W-`DC_PADDR_W){1'b0}}, req_q.paddr[`DC_PADDR_W-1:`DC_BANK_BIT],
         beat_q, 2'b00};

   assign fill_done_o       = state_q == dcache_pkg::FILL_DONE;
   assign line_fill_o.index = req_q.paddr[`DC_INDEX_HI:`DC_INDEX_LO];
   assign line_fill_o.tag   = req_q.paddr[`DC_PADDR_W-1:`DC_TAG_LO];
   assign line_fill_o.line  = line_q;
   assign fill_word_o = (req_q.op == dcache_pkg::OP_WRITE)
      ? req_q.wdata
      : line_q[word_sel*`DC_WORD_W +: `DC_WORD_W];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= dcache_pkg::FILL_IDLE;
         stb_q   <= 1'b0;
         beat_q  <= '0;
      end else begin
         case (state_q)
            dcache_pkg::FILL_IDLE: begin
               beat_q <= '0;
               if (fill_valid_i) begin
                  stb_q   <= 1'b1;
                  state_q <= (fill_req_i.op == dcache_pkg::OP_WRITE)
                             ? dcache_pkg::FILL_STORE : dcache_pkg::FILL_BEAT;
               end
            end
            dcache_pkg::FILL_BEAT: begin
               // One idle cycle between beats
               if (beat_end) begin
                  stb_q <= 1'b0;
                  if (beat_q == BEAT_W'(`DC_BEATS - 1)) begin
                     state_q <= dcache_pkg::FILL_DONE;
                  end else begin
                     beat_q <= beat_q + 1'b1;
                  end
               end else if (!stb_q) begin
                  stb_q <= 1'b1;
               end
            end
            dcache_pkg::FILL_STORE: begin
               if (beat_end) begin
                  stb_q   <= 1'b0;
                  state_q <= dcache_pkg::FILL_DONE;
               end
            end
            default: begin
               state_q <= dcache_pkg::FILL_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == dcache_pkg::FILL_IDLE && fill_valid_i) begin
         req_q <= fill_req_i;
      end
      if (state_q == dcache_pkg::FILL_BEAT && beat_end) begin
         line_q[beat_q*`DC_WORD_W +: `DC_WORD_W] <= mem_i.dat;
      end
   end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module dcache_top (
   input  logic                                         clk,
   input  logic                                         reset_i,
   input  dcache_pkg::wb_m2s_t                          core_i,
   output dcache_pkg::wb_s2m_t                          core_o,
   output dcache_pkg::wb_m2s_t                          mem_o,
   input  dcache_pkg::wb_s2m_t                          mem_i,
   input  dcache_pkg::tlb_entry_t [`DC_TLB_ENTRIES-1:0] tlb_entries_i,
   output dcache_pkg::fault_t                           fault_o
);

   logic                   xlat_valid;
   dcache_pkg::xlat_req_t  xlat_req;
   logic                   stage_done;
   logic                   tlb_err;
   logic                   bank_ack;
   logic [`DC_WORD_W-1:0]  bank_rdata;
   logic                   fill_valid;
   dcache_pkg::fill_req_t  fill_req;
   logic                   fill_done;
   dcache_pkg::line_fill_t line_fill;
   logic [`DC_WORD_W-1:0]  fill_word;

   tlb_stage u_tlb_stage (
      .clk          (clk),
      .reset_i      (reset_i),
      .core_i       (core_i),
      .tlb_entries_i(tlb_entries_i),
      .stage_done_i (stage_done),
      .xlat_valid_o (xlat_valid),
      .xlat_req_o   (xlat_req),
      .err_o        (tlb_err),
      .fault_o      (fault_o)
   );

   bank_stage u_bank_stage (
      .clk         (clk),
      .reset_i     (reset_i),
      .xlat_valid_i(xlat_valid),
      .xlat_req_i  (xlat_req),
      .fill_done_i (fill_done),
      .line_fill_i (line_fill),
      .fill_word_i (fill_word),
      .fill_valid_o(fill_valid),
      .fill_req_o  (fill_req),
      .ack_o       (bank_ack),
      .rdata_o     (bank_rdata),
      .stage_done_o(stage_done)
   );

   fill_stage u_fill_stage (
      .clk         (clk),
      .reset_i     (reset_i),
      .fill_valid_i(fill_valid),
      .fill_req_i  (fill_req),
      .mem_o       (mem_o),
      .mem_i       (mem_i),
      .fill_done_o (fill_done),
      .line_fill_o (line_fill),
      .fill_word_o (fill_word)
   );

   // Ack from the bank path, err from translation
   assign core_o.ack = bank_ack;
   assign core_o.err = tlb_err;
   assign core_o.dat = bank_rdata;

endmodule

//--- testbench/tb_wb_memory.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module tb_wb_memory (
   input  logic                clk,
   input  logic                reset_i,
   input  dcache_pkg::wb_m2s_t bus_i,
   output dcache_pkg::wb_s2m_t bus_o
);

   localparam int WORDS = 1 << (`DC_PADDR_W - 2);

   logic [`DC_WORD_W-1:0]    shadow [WORDS];
   int unsigned              beat_count;
   logic                     ack_q;
   logic [`DC_WORD_W-1:0]    dat_q;
   logic                     in_beat;
   int unsigned              wait_left;
   logic [`DC_PADDR_W-3:0]   word_idx;

   // Pattern mixes every address bit
   function automatic logic [`DC_WORD_W-1:0] fill_word(int unsigned a);
      return (a * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ a;
   endfunction

   assign word_idx  = bus_i.adr[`DC_PADDR_W-1:2];
   assign bus_o.ack = ack_q;
   assign bus_o.err = 1'b0;
   assign bus_o.dat = dat_q;

   always @(posedge clk) begin
      int unsigned waits;
      if (reset_i) begin
         ack_q      <= 1'b0;
         in_beat    <= 1'b0;
         wait_left  <= 0;
         beat_count <= 0;
         for (int a = 0; a < WORDS; a++) begin
            shadow[a] <= fill_word(a);
         end
      end else begin
         ack_q <= 1'b0;
         if (bus_i.cyc && bus_i.stb && !ack_q) begin
            // 0 to 2 wait states, drawn when a beat starts
            waits = in_beat ? wait_left : $urandom_range(2, 0);
            if (waits == 0) begin
               ack_q      <= 1'b1;
               in_beat    <= 1'b0;
               beat_count <= beat_count + 1;
               if (bus_i.we) begin
                  shadow[word_idx] <= bus_i.dat;
               end else begin
                  dat_q <= shadow[word_idx];
               end
            end else begin
               in_beat   <= 1'b1;
               wait_left <= waits - 1;
            end
         end
      end
   end

endmodule

//--- testbench/tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_consts.svh"

module tb_dcache;

   // Roughly 270 accesses of up to about 30 cycles each
   localparam int MAX_CYCLES      = 20000;
   localparam int RANDOM_ACCESSES = 250;
   localparam logic [`DC_VPN_W-1:0] VPN_BASE = 20'h00010;
   localparam int MAPPED_PAGES    = 6;
   localparam int WRITABLE_PAGES  = 4;

   typedef struct packed {
      logic [`DC_PADDR_W-1:0] paddr;
      dcache_pkg::fault_t     fault;
      logic [`DC_WORD_W-1:0]  word;
      int                     beats;
   } expect_t;

   logic                                         clk = 1'b0;
   logic                                         reset_i;
   dcache_pkg::wb_m2s_t                          core_i;
   dcache_pkg::wb_s2m_t                          core_o;
   dcache_pkg::wb_m2s_t                          mem_m2s;
   dcache_pkg::wb_s2m_t                          mem_s2m;
   dcache_pkg::tlb_entry_t [`DC_TLB_ENTRIES-1:0] tlb_entries;
   dcache_pkg::fault_t                           fault_o;
   int                                           cycle_count = 0;

   // Lines the cache should hold, keyed by bank and index
   logic                              line_valid [32];
   logic [`DC_PADDR_W-`DC_TAG_LO-1:0] line_tag   [32];

   expect_t               exp_q;
   dcache_pkg::mem_op_t   cur_op;
   logic                  got_err;
   logic [`DC_WORD_W-1:0] got_dat;
   logic [`DC_WORD_W-1:0] got_mem;
   dcache_pkg::fault_t    got_fault;
   int                    got_beats;
   event                  access_done;

   dcache_top i_dut (
      .clk          (clk),
      .reset_i      (reset_i),
      .core_i       (core_i),
      .core_o       (core_o),
      .mem_o        (mem_m2s),
      .mem_i        (mem_s2m),
      .tlb_entries_i(tlb_entries),
      .fault_o      (fault_o)
   );

   tb_wb_memory i_mem (
      .clk    (clk),
      .reset_i(reset_i),
      .bus_i  (mem_m2s),
      .bus_o  (mem_s2m)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         stop_on_error();
      end
   end

   task automatic stop_on_error();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input logic [`DC_WORD_W-1:0] got,
                             input logic [`DC_WORD_W-1:0] exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_fault(input dcache_pkg::fault_t got, input dcache_pkg::fault_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: fault is %s, expected %s", $time, got.name(), exp.name());
         stop_on_error();
      end
   endtask

   task automatic check_beats(input int got, input int exp);
      if (got != exp) begin
         $display("error at %0t ns: %0d memory beats, expected %0d", $time, got, exp);
         stop_on_error();
      end
   endtask

   function automatic logic [4:0] line_key(logic [`DC_PADDR_W-1:0] paddr);
      return {paddr[`DC_BANK_BIT], paddr[`DC_INDEX_HI:`DC_INDEX_LO]};
   endfunction

   // Expected outcome from the page map, the shadow memory and the cache contents
   function automatic expect_t expected_access(dcache_pkg::mem_op_t op,
                                               logic [`DC_VADDR_W-1:0] vaddr,
                                               logic [`DC_WORD_W-1:0] wdata);
      expect_t              e;
      logic [`DC_VPN_W-1:0] vpn;
      logic [`DC_VPN_W-1:0] page;
      logic [4:0]           key;
      vpn     = vaddr[`DC_VADDR_W-1:`DC_PAGE_OFS_W];
      page    = vpn - VPN_BASE;
      e.paddr = '0;
      e.fault = dcache_pkg::FAULT_NONE;
      e.word  = '0;
      e.beats = 0;
      if (vpn < VPN_BASE || page >= MAPPED_PAGES) begin
         e.fault = dcache_pkg::FAULT_TLB_MISS;
         return e;
      end
      e.paddr = {page[`DC_PFN_W-1:0], vaddr[`DC_PAGE_OFS_W-1:0]};
      key     = line_key(e.paddr);
      e.word  = i_mem.shadow[e.paddr[`DC_PADDR_W-1:2]];
      if (op == dcache_pkg::OP_WRITE) begin
         if (page >= WRITABLE_PAGES) begin
            e.fault = dcache_pkg::FAULT_PROTECTION;
         end else begin
            e.word  = wdata;
            e.beats = 1;
         end
      end else if (!(line_valid[key] && line_tag[key] == e.paddr[`DC_PADDR_W-1:`DC_TAG_LO])) begin
         e.beats = `DC_BEATS;
      end
      return e;
   endfunction

   // One Wishbone classic cycle, started and sampled on the falling edge
   task automatic do_access(input dcache_pkg::mem_op_t op, input logic [`DC_VADDR_W-1:0] vaddr,
                            input logic [`DC_WORD_W-1:0] wdata);
      core_i.cyc = 1'b1;
      core_i.stb = 1'b1;
      core_i.we  = (op == dcache_pkg::OP_WRITE);
      core_i.adr = vaddr;
      core_i.dat = wdata;
      do begin
         @(negedge clk);
      end while (!(core_o.ack || core_o.err));
      got_err    = core_o.err;
      got_dat    = core_o.dat;
      got_fault  = fault_o;
      core_i.cyc = 1'b0;
      core_i.stb = 1'b0;
      core_i.we  = 1'b0;
   endtask

   task automatic run_access(input dcache_pkg::mem_op_t op, input logic [`DC_VADDR_W-1:0] vaddr,
                             input logic [`DC_WORD_W-1:0] wdata);
      int unsigned beats_before;
      exp_q        = expected_access(op, vaddr, wdata);
      cur_op       = op;
      beats_before = i_mem.beat_count;
      do_access(op, vaddr, wdata);
      got_beats = int'(i_mem.beat_count - beats_before);
      got_mem   = i_mem.shadow[exp_q.paddr[`DC_PADDR_W-1:2]];
      -> access_done;
      // Idle cycle with stb low before the next request
      @(negedge clk);
   endtask

   always begin
      @(access_done);
      if (got_err != (exp_q.fault != dcache_pkg::FAULT_NONE)) begin
         $display("error at %0t ns: the DUT answered with %s where %s was expected",
                  $time, got_err ? "err" : "ack", got_err ? "ack" : "err");
         stop_on_error();
      end
      check_fault(got_fault, exp_q.fault);
      check_beats(got_beats, exp_q.beats);
      if (cur_op == dcache_pkg::OP_WRITE) begin
         // An unmapped write has no physical word to look at
         if (exp_q.fault != dcache_pkg::FAULT_TLB_MISS) begin
            check_word(got_mem, exp_q.word, "memory word after write");
         end
      end else if (exp_q.fault == dcache_pkg::FAULT_NONE) begin
         check_word(got_dat, exp_q.word, "read data");
         line_valid[line_key(exp_q.paddr)] = 1'b1;
         line_tag[line_key(exp_q.paddr)]   = exp_q.paddr[`DC_PADDR_W-1:`DC_TAG_LO];
      end
   end

   initial begin
      int                     page;
      logic [`DC_VPN_W-1:0]   vpn;
      logic [`DC_VADDR_W-1:0] vaddr;
      dcache_pkg::mem_op_t    op;
      void'($urandom(86851));
      reset_i = 1'b1;
      core_i  = '0;
      for (int k = 0; k < `DC_TLB_ENTRIES; k++) begin
         tlb_entries[k].valid    = (k < MAPPED_PAGES);
         tlb_entries[k].writable = (k < WRITABLE_PAGES);
         tlb_entries[k].vpn      = VPN_BASE + k[`DC_VPN_W-1:0];
         tlb_entries[k].pfn      = k[`DC_PFN_W-1:0];
      end
      for (int i = 0; i < 32; i++) begin
         line_valid[i] = 1'b0;
      end
      repeat (10) @(negedge clk);
      reset_i = 1'b0;
      @(negedge clk);

      // Line fill, then a hit in the same line
      run_access(dcache_pkg::OP_READ, 32'h0001_0040, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_0048, '0);
      // Write-through to a cached and to an uncached line
      run_access(dcache_pkg::OP_WRITE, 32'h0001_0044, 32'hcafe_0001);
      run_access(dcache_pkg::OP_READ, 32'h0001_0044, '0);
      run_access(dcache_pkg::OP_WRITE, 32'h0001_1100, 32'hcafe_0002);
      run_access(dcache_pkg::OP_READ, 32'h0001_1100, '0);
      // Opposite banks coexist
      run_access(dcache_pkg::OP_READ, 32'h0001_2200, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_2210, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_2200, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_2210, '0);
      // Same set, different tags
      run_access(dcache_pkg::OP_READ, 32'h0001_2300, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_3300, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_2300, '0);
      run_access(dcache_pkg::OP_READ, 32'h0001_3300, '0);
      // Unmapped pages
      run_access(dcache_pkg::OP_READ, 32'h0040_0000, '0);
      run_access(dcache_pkg::OP_WRITE, 32'h0001_6000, 32'h1234_5678);
      // Read-only page
      run_access(dcache_pkg::OP_WRITE, 32'h0001_4010, 32'hdead_beef);
      run_access(dcache_pkg::OP_READ, 32'h0001_4010, '0);

      // Small offsets so lines get reused and evicted
      for (int n = 0; n < RANDOM_ACCESSES; n++) begin
         page  = $urandom_range(8, 0);
         vpn   = (page == 8) ? 20'h00400 : VPN_BASE + page[`DC_VPN_W-1:0];
         vaddr = {vpn, 4'h0, 6'($urandom_range(63, 0)), 2'b00};
         op    = ($urandom_range(9, 0) < 3) ? dcache_pkg::OP_WRITE : dcache_pkg::OP_READ;
         run_access(op, vaddr, $urandom());
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- compile.f
+incdir+logic
logic/dcache_pkg.sv
logic/cache_bank.sv
logic/tlb_stage.sv
logic/bank_stage.sv
logic/fill_stage.sv
logic/dcache_top.sv
testbench/tb_wb_memory.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f compile.f \
   --top-module tb_dcache -o sim_dcache \
   && ./obj_dir/sim_dcache | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
   || { echo "simulation failed"; exit 1; }

echo "simulation passed"
exit 0
